//--- include/game_cfg.svh
/*
 * Build-time sizing of one game. Included by the package, the stage
 * logic and the testbench wherever the stage count is needed.
 */
`ifndef GAME_CFG_SVH
`define GAME_CFG_SVH

// stages played before the game is won
`define GAME_NUM_STAGES 4

// bits needed to index a stage
`define GAME_STAGE_W 2

`endif

//--- design/game_pkg.sv
/*
 * Types shared by the game control blocks: the FSM state encoding, the
 * stage index and the roster of object groups active in a stage.
 * Compile before any file that imports it.
 */
`include "game_cfg.svh"

package game_pkg;

    typedef enum logic [2:0] {
        ST_RESET,       // waiting for start
        ST_RUN,
        ST_PAUSE,
        ST_STAGE_WON,   // one cycle between stages
        ST_GAME_OVER
    } game_state_t;

    typedef logic [`GAME_STAGE_W-1:0] game_stage_t;

    // one active bit per object group
    typedef struct packed {
        logic monst;
        logic astero;
        logic boss;
        logic gift;
    } roster_t;

endpackage

//--- design/game_ctrl_if.sv
/*
 * Links the game FSM, the stage counter and the roster unit. The FSM
 * drives the run levels and the advance strobe, the counter returns
 * the stage index and the game-won level.
 */
interface game_ctrl_if (input logic clk);
    import game_pkg::*;

    logic        pause_enable;  // high while objects may move
    logic        clear_monst;   // hold monsters in reset
    logic        clear_others;  // hold asteroids, boss and gift in reset
    logic        advance;       // one-cycle stage cleared strobe
    logic        game_won;      // sticky until start drops
    game_stage_t stage_num;

    modport fsm (
        input  clk, game_won,
        output pause_enable, clear_monst, clear_others, advance
    );
    modport counter (
        input  clk, advance,
        output game_won, stage_num
    );
    modport roster (
        input  pause_enable, clear_monst, clear_others, stage_num
    );
endinterface

//--- design/input_conditioner.sv
/*
 * Samples the start and pause switches on the clock and turns the skip
 * button into a single-cycle pulse. Every output lags its input by one edge.
 */
module input_conditioner (
    input  logic clk,
    input  logic resetN,
    input  logic start_game,    // switch
    input  logic pause,         // switch
    input  logic skip_stage,    // push button, may be held
    output logic start_stable,
    output logic pause_stable,
    output logic skip_pulse
);

    logic skip_prev;    // skip level seen at the previous edge

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            start_stable <= 1'b0;
            pause_stable <= 1'b0;
            skip_prev    <= 1'b0;
            skip_pulse   <= 1'b0;
        end else begin
            start_stable <= start_game;     // a glitch between edges never reaches the fsm
            pause_stable <= pause;
            skip_prev    <= skip_stage;
            skip_pulse   <= skip_stage & ~skip_prev;    // rising edge only
        end
    end

endmodule

//--- design/game_fsm.sv
/*
 * Game state machine. Moves between reset, run, pause, stage won and game
 * over, and decodes the player controls and object clear levels from the
 * state. Issues the advance strobe when a stage is cleared in run.
 */
module game_fsm (
    input  logic        clk,
    input  logic        resetN,
    input  logic        start_stable,
    input  logic        pause_stable,
    input  logic        skip_pulse,
    input  logic        win_stage,      // from the enemy blocks
    input  logic        player_dead,    // from the lives counter
    game_ctrl_if.fsm    ctrl,
    output logic        enable_player,
    output logic        resetN_player,
    output logic        game_over
);
    import game_pkg::*;

    game_state_t state, next_state;

    // stage cleared in run, with nothing of higher priority pending
    assign ctrl.advance = (state == ST_RUN) && start_stable && !pause_stable &&
                          !player_dead && (win_stage || skip_pulse);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN)
            state <= ST_RESET;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET: begin
                if (start_stable) next_state = ST_RUN;
            end
            ST_RUN: begin
                if (pause_stable)      next_state = ST_PAUSE;
                else if (player_dead)  next_state = ST_GAME_OVER;
                else if (ctrl.advance) next_state = ST_STAGE_WON;
            end
            ST_PAUSE: begin
                if (!pause_stable) next_state = ST_RUN;
            end
            ST_STAGE_WON: begin
                // the counter has already flagged the last stage
                next_state = ctrl.game_won ? ST_GAME_OVER : ST_RUN;
            end
            ST_GAME_OVER: begin
                next_state = ST_GAME_OVER;  // wait for start to drop
            end
            default: next_state = ST_RESET;
        endcase
        if (!start_stable) next_state = ST_RESET;  // start low wins over everything
    end

    // moore decode of the controls
    always_comb begin
        enable_player     = 1'b1;
        resetN_player     = 1'b1;
        game_over         = 1'b0;
        ctrl.pause_enable = 1'b1;
        ctrl.clear_monst  = 1'b0;
        ctrl.clear_others = 1'b0;
        case (state)
            ST_RESET, ST_GAME_OVER: begin
                enable_player     = 1'b0;
                resetN_player     = 1'b0;
                ctrl.pause_enable = 1'b0;
                ctrl.clear_monst  = 1'b1;
                ctrl.clear_others = 1'b1;
                game_over         = (state == ST_GAME_OVER);
            end
            ST_PAUSE: begin
                enable_player     = 1'b0;   // objects freeze but keep their state
                ctrl.pause_enable = 1'b0;
            end
            ST_STAGE_WON: begin
                ctrl.clear_monst  = 1'b1;   // fresh monster wave for the next stage
            end
            default: ;
        endcase
    end

endmodule

//--- design/stage_counter.sv
/*
 * Counts cleared stages. Steps the stage index on each advance strobe and
 * raises the sticky game-won level when the last stage is cleared.
 * Start going low clears both.
 */
`include "game_cfg.svh"

module stage_counter (
    input  logic          clk,
    input  logic          resetN,
    input  logic          start_stable,
    game_ctrl_if.counter  ctrl
);
    import game_pkg::*;

    localparam game_stage_t LAST_STAGE = game_stage_t'(`GAME_NUM_STAGES - 1);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            ctrl.stage_num <= '0;
            ctrl.game_won  <= 1'b0;
        end else if (!start_stable) begin
            ctrl.stage_num <= '0;    // new game starts at stage 0
            ctrl.game_won  <= 1'b0;
        end else if (ctrl.advance) begin
            if (ctrl.stage_num == LAST_STAGE)
                ctrl.game_won  <= 1'b1;    // index stays on the last stage
            else
                ctrl.stage_num <= ctrl.stage_num + game_stage_t'(1);
        end
    end

endmodule

//--- design/stage_roster.sv
/*
 * Stage table and object gating. Looks up which object groups play in the
 * current stage, enables them while the game runs and holds absent or
 * cleared groups in reset.
 */
`include "game_cfg.svh"

module stage_roster (
    game_ctrl_if.roster  ctrl,
    output logic         enable_monst,
    output logic         enable_astero,
    output logic         enable_boss,
    output logic         enable_gift,
    output logic         resetN_monst,
    output logic         resetN_astero,
    output logic         resetN_boss,
    output logic         resetN_gift
);
    import game_pkg::*;

    // order of each entry is monst, astero, boss, gift
    localparam roster_t STAGE_TABLE [`GAME_NUM_STAGES] = '{
        '{1'b1, 1'b0, 1'b0, 1'b0},  // monsters only
        '{1'b1, 1'b1, 1'b0, 1'b0},  // monsters and asteroids
        '{1'b1, 1'b0, 1'b0, 1'b1},  // monsters and gift
        '{1'b0, 1'b0, 1'b1, 1'b1}   // boss fight with gift
    };

    roster_t active;

    assign active = STAGE_TABLE[ctrl.stage_num];

    assign enable_monst  = ctrl.pause_enable & active.monst;
    assign enable_astero = ctrl.pause_enable & active.astero;
    assign enable_boss   = ctrl.pause_enable & active.boss;
    assign enable_gift   = ctrl.pause_enable & active.gift;

    // pause does not touch the resets, so frozen objects keep their state
    assign resetN_monst  = active.monst  & ~ctrl.clear_monst;
    assign resetN_astero = active.astero & ~ctrl.clear_others;
    assign resetN_boss   = active.boss   & ~ctrl.clear_others;
    assign resetN_gift   = active.gift   & ~ctrl.clear_others;

endmodule

//--- design/game_controller.sv
/*
 * Top of the game control. Conditions the switches, runs the game FSM,
 * counts stages and drives the enable and reset strobes of the player and
 * each object group.
 */
module game_controller (
    input  logic                 clk,
    input  logic                 resetN,
    input  logic                 start_game,     // switch
    input  logic                 win_stage,      // enemy group destroyed
    input  logic                 player_dead,    // last life lost
    input  logic                 skip_stage,     // cheat button
    input  logic                 pause,          // switch
    output logic                 game_won,
    output logic                 game_over,
    output logic                 enable_player,
    output logic                 enable_monst,
    output logic                 enable_astero,
    output logic                 enable_boss,
    output logic                 enable_gift,
    output logic                 resetN_player,
    output logic                 resetN_monst,
    output logic                 resetN_astero,
    output logic                 resetN_boss,
    output logic                 resetN_gift,
    output game_pkg::game_stage_t stage_num
);

    logic start_stable;
    logic pause_stable;
    logic skip_pulse;

    game_ctrl_if ctrl_if (.clk(clk));

    input_conditioner i_cond (
        .clk          (clk),
        .resetN       (resetN),
        .start_game   (start_game),
        .pause        (pause),
        .skip_stage   (skip_stage),
        .start_stable (start_stable),
        .pause_stable (pause_stable),
        .skip_pulse   (skip_pulse)
    );

    game_fsm i_fsm (
        .clk           (clk),
        .resetN        (resetN),
        .start_stable  (start_stable),
        .pause_stable  (pause_stable),
        .skip_pulse    (skip_pulse),
        .win_stage     (win_stage),
        .player_dead   (player_dead),
        .ctrl          (ctrl_if.fsm),
        .enable_player (enable_player),
        .resetN_player (resetN_player),
        .game_over     (game_over)
    );

    stage_counter i_counter (
        .clk          (clk),
        .resetN       (resetN),
        .start_stable (start_stable),
        .ctrl         (ctrl_if.counter)
    );

    stage_roster i_roster (
        .ctrl          (ctrl_if.roster),
        .enable_monst  (enable_monst),
        .enable_astero (enable_astero),
        .enable_boss   (enable_boss),
        .enable_gift   (enable_gift),
        .resetN_monst  (resetN_monst),
        .resetN_astero (resetN_astero),
        .resetN_boss   (resetN_boss),
        .resetN_gift   (resetN_gift)
    );

    assign game_won  = ctrl_if.game_won;
    assign stage_num = ctrl_if.stage_num;

endmodule

//--- verification/game_assertions.sv
/*
 * Concurrent checks on the game controller outputs, bound into the RTL
 * top level. A violation is raised as an assertion error.
 */
module game_assertions (
    input logic clk,
    input logic resetN,
    input logic game_won,
    input logic game_over,
    input logic enable_player,
    input logic enable_monst,
    input logic enable_astero,
    input logic enable_boss,
    input logic enable_gift,
    input logic resetN_monst,
    input logic resetN_astero,
    input logic resetN_boss,
    input logic resetN_gift
);

    player_idle_when_over: assert property (@(posedge clk) disable iff (!resetN)
        game_over |-> !enable_player)
        else $error("player enabled during game over");

    // asteroids, boss and gift never run while held in reset
    others_out_of_reset: assert property (@(posedge clk) disable iff (!resetN)
        !((enable_astero && !resetN_astero) || (enable_boss && !resetN_boss) ||
          (enable_gift && !resetN_gift)))
        else $error("object group enabled while held in reset");

    // monsters are cleared only for the single cycle between stages
    monst_clear_one_cycle: assert property (@(posedge clk) disable iff (!resetN)
        (enable_monst && !resetN_monst) |=> (resetN_monst || !enable_monst))
        else $error("monsters enabled in reset for more than one cycle");

    won_leads_to_over: assert property (@(posedge clk) disable iff (!resetN)
        $rose(game_won) |=> game_over)
        else $error("game won without the move to game over");

endmodule

bind game_controller game_assertions i_assertions (
    .clk, .resetN, .game_won, .game_over, .enable_player,
    .enable_monst, .enable_astero, .enable_boss, .enable_gift,
    .resetN_monst, .resetN_astero, .resetN_boss, .resetN_gift
);

//--- verification/tb_game_controller.sv
/*
 * Testbench for the game controller. Plays games through the switch and
 * button inputs and compares every output with a stage table model.
 */
`include "game_cfg.svh"

module tb_game_controller;
    import game_pkg::*;

    localparam game_stage_t LAST_STAGE = game_stage_t'(`GAME_NUM_STAGES - 1);
    localparam int WAIT_LIMIT = 20;     // cycles allowed for any state change

    logic clk, resetN;
    logic start_game, win_stage, player_dead, skip_stage, pause;
    logic game_won, game_over, enable_player, resetN_player;
    logic enable_monst, enable_astero, enable_boss, enable_gift;
    logic resetN_monst, resetN_astero, resetN_boss, resetN_gift;
    game_stage_t stage_num;

    game_stage_t exp_stage;
    game_state_t exp_state;
    logic        exp_won;
    int          mismatches;
    int          timeouts;
    event        check_ev;      // wakes the comparing process

    game_controller i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // expected groups for a stage, as enables or as active-low resets
    function automatic roster_t ref_roster(input game_stage_t s, input game_state_t st,
                                           input bit resets);
        roster_t r;
        case (int'(s))
            0:       r = 4'b1000;   // monsters
            1:       r = 4'b1100;   // monsters and asteroids
            2:       r = 4'b1001;   // monsters and gift
            default: r = 4'b0011;   // boss and gift
        endcase
        if (st == ST_RESET || st == ST_GAME_OVER || (st == ST_PAUSE && !resets))
            r = '0;                 // paused groups freeze but stay out of reset
        return r;
    endfunction

    function automatic bit reached(input game_state_t st);
        case (st)
            ST_RUN:       return enable_player && resetN_player;
            ST_PAUSE:     return !enable_player && resetN_player;
            ST_GAME_OVER: return game_over;
            default:      return !resetN_player && !game_over;
        endcase
    endfunction

    task automatic check_stage(input game_stage_t got, input game_stage_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_roster(input roster_t got, input roster_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s are %b, expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // wait until the outputs show a state, then compare one cycle later
    task automatic expect_state(input game_state_t st);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!reached(st) && n < WAIT_LIMIT);
        if (!reached(st)) begin
            $display("timeout at %0t: outputs never showed the %s state", $time, st.name());
            timeouts++;
        end
        @(negedge clk);
        exp_state = st;
        -> check_ev;
    endtask

    task automatic start_run();
        @(posedge clk);
        start_game <= 1'b1;
        expect_state(ST_RUN);
    endtask

    task automatic stop_game();
        @(posedge clk);
        start_game <= 1'b0;
        pause      <= 1'b0;
        exp_stage = '0;
        exp_won   = 1'b0;
        expect_state(ST_RESET);
    endtask

    task automatic clear_stage(input bit by_skip, input int hold);
        @(posedge clk);
        if (by_skip)
            skip_stage <= 1'b1;
        else
            win_stage <= 1'b1;
        repeat (hold) @(posedge clk);
        skip_stage <= 1'b0;
        win_stage  <= 1'b0;
        repeat (2) @(posedge clk);      // stage won lasts one cycle
        if (exp_stage == LAST_STAGE)
            exp_won = 1'b1;
        else
            exp_stage++;
        expect_state(exp_won ? ST_GAME_OVER : ST_RUN);
    endtask

    initial forever begin
        @(check_ev);
        check_stage(stage_num, exp_stage, "stage_num");
        check_roster({enable_monst, enable_astero, enable_boss, enable_gift},
                     ref_roster(exp_stage, exp_state, 1'b0), "enables");
        check_roster({resetN_monst, resetN_astero, resetN_boss, resetN_gift},
                     ref_roster(exp_stage, exp_state, 1'b1), "resets");
        check_flag(game_won, exp_won, "game_won");
        check_flag(game_over, exp_state == ST_GAME_OVER, "game_over");
        check_flag(enable_player, exp_state == ST_RUN, "enable_player");
        check_flag(resetN_player, exp_state inside {ST_RUN, ST_PAUSE}, "resetN_player");
    end

    initial begin
        int n_skips;
        void'($urandom(32'h9d43));
        mismatches = 0;
        timeouts   = 0;
        exp_stage  = '0;
        exp_won    = 1'b0;
        exp_state  = ST_RESET;
        resetN      <= 1'b0;
        start_game  <= 1'b0;
        win_stage   <= 1'b0;
        player_dead <= 1'b0;
        skip_stage  <= 1'b0;
        pause       <= 1'b0;
        repeat (4) @(posedge clk);
        resetN <= 1'b1;
        expect_state(ST_RESET);
        repeat (3) @(posedge clk);
        expect_state(ST_RESET);         // start still low

        start_run();
        clear_stage(1'b0, 1);
        @(posedge clk);
        pause <= 1'b1;
        expect_state(ST_PAUSE);
        @(posedge clk);
        pause <= 1'b0;
        expect_state(ST_RUN);
        clear_stage(1'b1, 5);           // held button counts once
        clear_stage(1'b0, 1);
        clear_stage(1'b0, 1);           // last stage ends the game
        stop_game();

        start_run();
        n_skips = $urandom_range(1, 3);
        repeat (n_skips) begin
            @(posedge clk);
            skip_stage <= 1'b1;
            @(posedge clk);
            skip_stage <= 1'b0;
            repeat ($urandom_range(1, 4)) @(posedge clk);
            exp_stage++;
        end
        expect_state(ST_RUN);
        @(posedge clk);
        pause <= 1'b1;
        expect_state(ST_PAUSE);
        stop_game();                    // start dropped while paused

        start_run();
        @(posedge clk);
        player_dead <= 1'b1;
        @(posedge clk);
        player_dead <= 1'b0;
        expect_state(ST_GAME_OVER);
        stop_game();

        @(posedge clk);
        $display("errors: %0d (mismatches %0d, timeouts %0d)",
                 mismatches + timeouts, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- game_controller.f
+incdir+include
design/game_pkg.sv
design/game_ctrl_if.sv
design/input_conditioner.sv
design/game_fsm.sv
design/stage_counter.sv
design/stage_roster.sv
design/game_controller.sv
verification/game_assertions.sv
verification/tb_game_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the game controller testbench with Verilator, runs it and
# looks for the pass line in the simulation output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_game_controller -f game_controller.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_game_controller)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "STATUS: PASS" <<< "$output"; then
    exit 0
fi
exit 1
